//--- build.f
rtl/core_pkg.sv
rtl/wakeup_pkg.sv
rtl/dependency_matrix.sv
rtl/free_entry_pool.sv
rtl/latency_countdown.sv
rtl/issue_select.sv
rtl/wakeup_logic.sv
rtl/issue_wakeup_top.sv
sim/issue_wakeup_properties.sv
sim/issue_wakeup_tb.sv

//--- rtl/core_pkg.sv
package core_pkg;

    // --------------------
    // Core sizes
    // --------------------
    localparam int rs_entries = 8;  // Reservation-station entries
    localparam int num_fus    = 3;  // Two ALUs and one multiplier
    localparam int lat_w      = 3;  // Wide enough for the slowest FU

    // --------------------
    // Meaningful widths
    // --------------------
    typedef logic [2:0]            entry_idx_t;   // Entry index
    typedef logic [1:0]            fu_id_t;       // FU index
    typedef logic [7:0]            tag_t;         // Instruction tag
    typedef logic [lat_w-1:0]      lat_t;         // Grant-to-result cycles
    typedef logic [rs_entries-1:0] entry_vec_t;   // One bit per entry
    typedef logic [3:0]            credit_cnt_t;  // 0 to rs_entries credits

    // --------------------
    // FU latency table
    // --------------------
    // Cycles from grant until the result can wake a consumer
    // FU 0 and FU 1 are the single-cycle ALUs, FU 2 the multiplier
    localparam lat_t fu_latency [num_fus] = '{
        3'd1,  // ALU 0
        3'd1,  // ALU 1
        3'd3   // Multiplier
    };

endpackage

//--- rtl/dependency_matrix.sv
`timescale 1ns/1ps

// Dependency bits for producers that run on one FU
// Row r, column c set while entry r waits on entry c
module dependency_matrix (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 w_en,        // Load a row on dispatch
    input  core_pkg::entry_idx_t w_row,       // Row being allocated
    input  core_pkg::entry_vec_t set_cols,    // Producers of the new row
    input  core_pkg::entry_vec_t clear_cols,  // Producers whose result is ready
    input  logic                 free_en,     // Zero a row on completion
    input  core_pkg::entry_idx_t free_row,
    output core_pkg::entry_vec_t wait_vec     // Row still has a bit set
);
    import core_pkg::*;

    entry_vec_t dep_bits [rs_entries];

    // --------------------
    // Bit array update
    // --------------------
    // Order matters: column clear, then row free, then row write
    // The write masks set_cols with clear_cols so a producer
    // finishing in the dispatch cycle leaves no stale dependency
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < rs_entries; r++) begin
                dep_bits[r] <= '0;
            end
        end else begin
            for (int r = 0; r < rs_entries; r++) begin
                dep_bits[r] <= dep_bits[r] & ~clear_cols;  // Wake every waiter
            end
            if (free_en) begin
                dep_bits[free_row] <= '0;
            end
            if (w_en) begin
                dep_bits[w_row] <= set_cols & ~clear_cols;  // Clear wins over set
            end
        end
    end

    // --------------------
    // Row reduction
    // --------------------
    always_comb begin
        for (int r = 0; r < rs_entries; r++) begin
            wait_vec[r] = |dep_bits[r];  // Any producer still outstanding
        end
    end

endmodule

//--- rtl/free_entry_pool.sv
`timescale 1ns/1ps

// Free-entry bitmap, lowest free index first
// Several entries may come back in one cycle
module free_entry_pool (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 alloc_en,     // Take alloc_index this cycle
    input  core_pkg::entry_vec_t release_vec,  // Entries completing this cycle
    output core_pkg::entry_idx_t alloc_index,
    output logic                 any_free
);
    import core_pkg::*;

    entry_vec_t free_bits;   // 1 = entry available
    entry_vec_t alloc_mask;  // One-hot of the allocated entry

    // Released entries become free at the next edge, with their credit
    assign any_free = |free_bits;

    // Priority encoder, low index wins
    always_comb begin
        alloc_index = '0;
        alloc_mask  = '0;
        for (int e = rs_entries - 1; e >= 0; e--) begin
            if (free_bits[e]) begin
                alloc_index = entry_idx_t'(e);
                alloc_mask  = entry_vec_t'(1) << e;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            free_bits <= '1;  // Everything free out of reset
        end else if (alloc_en && any_free) begin
            free_bits <= (free_bits & ~alloc_mask) | release_vec;
        end else begin
            free_bits <= free_bits | release_vec;
        end
    end

endmodule

//--- rtl/issue_select.sv
`timescale 1ns/1ps

// Select stage
// One grant per FU, lowest requesting index wins
module issue_select (
    input  core_pkg::entry_vec_t request_vec [core_pkg::num_fus],
    output core_pkg::entry_vec_t grant_vec   [core_pkg::num_fus]
);
    import core_pkg::*;

    // --------------------
    // Fixed-priority arbiters
    // --------------------
    // FUs are disjoint by construction: an entry only ever
    // requests on its own FU, so the arbiters need no coupling
    always_comb begin
        logic found;
        for (int f = 0; f < num_fus; f++) begin
            found        = 1'b0;
            grant_vec[f] = '0;
            for (int e = 0; e < rs_entries; e++) begin
                if (request_vec[f][e] && !found) begin
                    grant_vec[f][e] = 1'b1;  // First request from the bottom
                    found           = 1'b1;
                end
            end
        end
    end

endmodule

//--- rtl/issue_wakeup_top.sv
`timescale 1ns/1ps

// Issue queue wakeup and select stage
module issue_wakeup_top (
    input  logic                      clk,
    input  logic                      rst,
    input  wakeup_pkg::dispatch_req_t dispatch,       // Credit-based, one per cycle
    output core_pkg::entry_idx_t      alloc_index,    // Entry for the next dispatch
    output core_pkg::credit_cnt_t     credit_return,  // Credits back this cycle
    output wakeup_pkg::issue_t        issue [core_pkg::num_fus]
);
    import core_pkg::*;

    entry_vec_t request_vec [num_fus];  // Ready and unissued, per FU
    entry_vec_t grant_vec   [num_fus];  // At most one bit per FU

    // --------------------
    // Wakeup
    // --------------------
    wakeup_logic u_wakeup (
        .clk           (clk),
        .rst           (rst),
        .dispatch      (dispatch),
        .alloc_index   (alloc_index),
        .credit_return (credit_return),
        .request_vec   (request_vec),
        .grant_vec     (grant_vec),
        .issue         (issue)
    );

    // --------------------
    // Select
    // --------------------
    issue_select u_select (
        .request_vec (request_vec),
        .grant_vec   (grant_vec)
    );

endmodule

//--- rtl/latency_countdown.sv
`timescale 1ns/1ps

// Per-producer latency counter
// Loaded at the grant edge, done pulses latency cycles later
module latency_countdown (
    input  logic           clk,
    input  logic           rst,
    input  logic           load,     // Entry granted this cycle
    input  core_pkg::lat_t latency,  // Latency of the entry's FU
    output logic           done      // Result available, one cycle
);
    import core_pkg::*;

    lat_t count;
    logic running;

    // --------------------
    // Down-counter
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            count   <= '0;
            running <= 1'b0;
        end else if (load) begin
            count   <= latency;
            running <= 1'b1;
        end else if (running) begin
            if (count == '0) begin
                running <= 1'b0;  // Pulse finished
            end else begin
                count <= count - lat_t'(1);
            end
        end
    end

    // High during the cycle that starts latency edges after the load edge
    assign done = running && (count == '0);

endmodule

//--- rtl/wakeup_logic.sv
`timescale 1ns/1ps

// Entry table, dependency tracking and wakeup
module wakeup_logic (
    input  logic                      clk,
    input  logic                      rst,
    input  wakeup_pkg::dispatch_req_t dispatch,
    output core_pkg::entry_idx_t      alloc_index,
    output core_pkg::credit_cnt_t     credit_return,
    output core_pkg::entry_vec_t      request_vec [core_pkg::num_fus],
    input  core_pkg::entry_vec_t      grant_vec   [core_pkg::num_fus],
    output wakeup_pkg::issue_t        issue       [core_pkg::num_fus]
);
    import core_pkg::*;

    // --------------------
    // Entry table
    // --------------------
    entry_vec_t ent_valid;   // Entry holds an instruction
    entry_vec_t ent_issued;  // Granted, waiting for its countdown
    fu_id_t     ent_fu  [rs_entries];
    tag_t       ent_tag [rs_entries];

    logic       any_free;
    logic       accept;                  // Dispatch written this cycle
    entry_vec_t set_cols  [num_fus];     // Producer columns per matrix
    entry_vec_t wait_vec  [num_fus];
    entry_vec_t waiting;                 // Any matrix flags the row
    entry_vec_t granted;                 // Grants over all FUs
    entry_vec_t done_vec;                // Countdowns ending this cycle
    entry_idx_t grant_idx [num_fus];
    entry_idx_t free_row;
    logic       free_en;

    assign accept = dispatch.valid && any_free;

    always_ff @(posedge clk) begin
        if (rst) begin
            ent_valid  <= '0;
            ent_issued <= '0;
        end else begin
            ent_valid  <= ent_valid & ~done_vec;  // Completed entries leave
            ent_issued <= (ent_issued | granted) & ~done_vec;
            if (accept) begin
                ent_valid[alloc_index]  <= 1'b1;  // Reuse of a freed entry wins
                ent_issued[alloc_index] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ent_fu[alloc_index]  <= dispatch.fu;
            ent_tag[alloc_index] <= dispatch.tag;
        end
    end

    // --------------------
    // Set lines
    // --------------------
    // Each source lands in the matrix of the producer's FU
    always_comb begin
        for (int f = 0; f < num_fus; f++) begin
            set_cols[f] = '0;
            if (dispatch.src1_en && ent_valid[dispatch.src1_entry] &&
                ent_fu[dispatch.src1_entry] == fu_id_t'(f)) begin
                set_cols[f][dispatch.src1_entry] = 1'b1;
            end
            if (dispatch.src2_en && ent_valid[dispatch.src2_entry] &&
                ent_fu[dispatch.src2_entry] == fu_id_t'(f)) begin
                set_cols[f][dispatch.src2_entry] = 1'b1;
            end
        end
    end

    // Rows of completed entries are already empty
    // the lowest one is cleared as a guard
    always_comb begin
        free_row = '0;
        for (int e = rs_entries - 1; e >= 0; e--) begin
            if (done_vec[e]) free_row = entry_idx_t'(e);
        end
    end
    assign free_en = |done_vec;

    for (genvar f = 0; f < num_fus; f++) begin : g_matrix
        dependency_matrix u_matrix (
            .clk        (clk),
            .rst        (rst),
            .w_en       (accept),
            .w_row      (alloc_index),
            .set_cols   (set_cols[f]),
            .clear_cols (done_vec),  // A result wakes waiters in every matrix
            .free_en    (free_en),
            .free_row   (free_row),
            .wait_vec   (wait_vec[f])
        );
    end

    free_entry_pool u_pool (
        .clk         (clk),
        .rst         (rst),
        .alloc_en    (accept),
        .release_vec (done_vec),
        .alloc_index (alloc_index),
        .any_free    (any_free)
    );

    // --------------------
    // Request and grant
    // --------------------
    always_comb begin
        waiting = '0;
        granted = '0;
        for (int f = 0; f < num_fus; f++) begin
            waiting = waiting | wait_vec[f];
            granted = granted | grant_vec[f];
        end
        for (int f = 0; f < num_fus; f++) begin
            grant_idx[f] = '0;
            for (int e = 0; e < rs_entries; e++) begin
                request_vec[f][e] = ent_valid[e] && !ent_issued[e] && !waiting[e] &&
                                    (ent_fu[e] == fu_id_t'(f));
                if (grant_vec[f][e]) grant_idx[f] = entry_idx_t'(e);  // One-hot to index
            end
        end
    end

    // Issue slots, one cycle behind the grant
    always_ff @(posedge clk) begin
        for (int f = 0; f < num_fus; f++) begin
            if (rst) begin
                issue[f].valid <= 1'b0;
            end else begin
                issue[f].valid <= |grant_vec[f];
            end
            issue[f].entry <= grant_idx[f];
            issue[f].tag   <= ent_tag[grant_idx[f]];
        end
    end

    // --------------------
    // Countdowns and credits
    // --------------------
    for (genvar e = 0; e < rs_entries; e++) begin : g_countdown
        latency_countdown u_countdown (
            .clk     (clk),
            .rst     (rst),
            .load    (granted[e]),
            .latency (fu_latency[ent_fu[e]]),  // Producer knows its own FU
            .done    (done_vec[e])
        );
    end

    always_comb begin
        credit_return = '0;
        for (int e = 0; e < rs_entries; e++) begin
            credit_return = credit_return + credit_cnt_t'(done_vec[e]);  // Popcount
        end
    end

endmodule

//--- rtl/wakeup_pkg.sv
package wakeup_pkg;

    // --------------------
    // Dispatch request
    // --------------------
    // One instruction per cycle from the dispatcher
    // A source names the entry of its producer, not a register
    typedef struct packed {
        logic                 valid;       // Instruction present this cycle
        core_pkg::fu_id_t     fu;          // Target FU
        core_pkg::tag_t       tag;         // Carried through to the issue slot
        logic                 src1_en;     // Source 1 waits on a producer
        core_pkg::entry_idx_t src1_entry;  // Producer entry of source 1
        logic                 src2_en;     // Source 2 waits on a producer
        core_pkg::entry_idx_t src2_entry;  // Producer entry of source 2
    } dispatch_req_t;

    // --------------------
    // Issue slot
    // --------------------
    // One per FU, registered, no back-pressure
    typedef struct packed {
        logic                 valid;  // Slot carries an instruction
        core_pkg::entry_idx_t entry;  // Entry that was granted
        core_pkg::tag_t       tag;    // Tag of that entry
    } issue_t;

endpackage

//--- sim/issue_wakeup_properties.sv
`timescale 1ns/1ps

// Protocol checks on the wakeup logic
module issue_wakeup_properties (
    input logic                      clk,
    input logic                      rst,
    input wakeup_pkg::dispatch_req_t dispatch,
    input logic                      any_free,
    input core_pkg::entry_vec_t      ent_issued,
    input core_pkg::credit_cnt_t     credit_return,
    input wakeup_pkg::issue_t        issue [core_pkg::num_fus]
);
    import core_pkg::*;

    int unsigned fail_count = 0;  // Failed assertions so far
    logic        any_valid;       // Some slot carries an instruction
    logic        dup_entry;       // Two slots name one entry

    always_comb begin
        any_valid = 1'b0;
        dup_entry = 1'b0;
        for (int a = 0; a < num_fus; a++) begin
            any_valid = any_valid | issue[a].valid;
            for (int b = a + 1; b < num_fus; b++) begin
                if (issue[a].valid && issue[b].valid &&
                    issue[a].entry == issue[b].entry) begin
                    dup_entry = 1'b1;
                end
            end
        end
    end

    // --------------------
    // Assertions
    // --------------------
    assert property (@(posedge clk) rst |=> (credit_return == '0) && !any_valid)
        else begin
            $error("issue or credit activity right after reset");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (rst) dispatch.valid |-> any_free)
        else begin
            $error("dispatch offered while no entry is free");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (rst) !dup_entry)
        else begin
            $error("one entry issued on two FUs in the same cycle");
            fail_count++;
        end

    // Only issued entries can finish, which also bounds it by rs_entries
    assert property (@(posedge clk) disable iff (rst)
                     int'(credit_return) <= $countones(ent_issued))
        else begin
            $error("credit_return above the number of issued entries");
            fail_count++;
        end

endmodule

bind wakeup_logic issue_wakeup_properties u_props (.*);

//--- sim/issue_wakeup_tb.sv
`timescale 1ns/1ps

module issue_wakeup_tb;
    import core_pkg::*;
    import wakeup_pkg::*;

    localparam int max_tags   = 256;
    localparam int wait_limit = 500;  // Cycles any single wait may take

    logic          clk = 1'b0;
    logic          rst = 1'b1;
    dispatch_req_t dispatch = '0;
    entry_idx_t    alloc_index;
    credit_cnt_t   credit_return;
    issue_t        issue [num_fus];

    // --------------------
    // Model table per tag
    // --------------------
    int disp_cyc  [max_tags];     // Edge that accepts the dispatch
    int issue_cyc [max_tags];     // Edge where the slot is sampled
    int done_cyc  [max_tags];     // Edge where its credit is due
    int fu_of     [max_tags];
    int entry_of  [max_tags];
    int prod      [max_tags][2];  // Producer tags, -1 if none
    bit sent      [max_tags];
    bit issued    [max_tags];
    bit returned  [max_tags];

    int cyc;           // Rising edges so far
    int credits;       // Held by the dispatcher
    int stall_cycles;  // Cycles the dispatcher waited for a credit
    int next_tag;
    int errors;
    int credit_total;  // Running sum of credit_return
    int tests_run;
    int tests_ok;
    int err_mark;      // Snapshots at test start
    int tag_mark;
    int credit_mark;

    always #5 clk = ~clk;

    issue_wakeup_top dut0 (
        .clk           (clk),
        .rst           (rst),
        .dispatch      (dispatch),
        .alloc_index   (alloc_index),
        .credit_return (credit_return),
        .issue         (issue)
    );

    task automatic value_mismatch(input string name, input int got, input int exp);
        $display("[ERROR] %s got %h expected %h", name, got, exp);
        errors++;
    endtask

    task automatic protocol_fault(input string what);
        $display("Check failed at cycle %0d: %s", cyc, what);
        errors++;
    endtask

    task automatic abort_run(input string what);
        $display("Timeout at cycle %0d: %s", cyc, what);
        $display("Test failed");
        $finish;
    endtask

    // Reference earliest issue cycle from dispatch and producer results
    function automatic int earliest_issue(input int t);
        int e;
        int p;
        e = disp_cyc[t] + 2;
        for (int s = 0; s < 2; s++) begin
            p = prod[t][s];
            if (p >= 0 && !issued[p]) begin
                return 32'h7fff_ffff;  // Producer not issued yet
            end
            if (p >= 0 && issue_cyc[p] + int'(fu_latency[fu_of[p]]) > e) begin
                e = issue_cyc[p] + int'(fu_latency[fu_of[p]]);
            end
        end
        return e;
    endfunction

    // Entry held by a tag until its credit has come back
    function automatic int lowest_free_entry();
        bit busy [rs_entries];
        int r;
        for (int e = 0; e < rs_entries; e++) begin
            busy[e] = 1'b0;
        end
        for (int t = 0; t < next_tag; t++) begin
            if (sent[t] && !returned[t]) begin
                busy[entry_of[t]] = 1'b1;
            end
        end
        r = -1;
        for (int e = rs_entries - 1; e >= 0; e--) begin
            if (!busy[e]) r = e;
        end
        return r;
    endfunction

    // --------------------
    // Compare process
    // --------------------
    always @(posedge clk) begin
        int t;
        int due;
        cyc = cyc + 1;
        if (!rst) begin
            for (int f = 0; f < num_fus; f++) begin
                if (issue[f].valid) begin
                    t = int'(issue[f].tag);
                    assert (sent[t] && !issued[t]) else
                        protocol_fault($sformatf("tag %0d issued twice or never sent", t));
                    if (sent[t] && !issued[t]) begin
                        assert (fu_of[t] == f) else
                            value_mismatch($sformatf("issue[%0d] FU", f), f, fu_of[t]);
                        assert (int'(issue[f].entry) == entry_of[t]) else
                            value_mismatch($sformatf("issue[%0d].entry", f),
                                           int'(issue[f].entry), entry_of[t]);
                        assert (cyc >= earliest_issue(t)) else
                            protocol_fault($sformatf("tag %0d issued before its producers", t));
                        issued[t]    = 1'b1;
                        issue_cyc[t] = cyc;
                        done_cyc[t]  = cyc + int'(fu_latency[f]);  // Credit due here
                    end
                end
            end
            due = 0;
            for (int k = 0; k < max_tags; k++) begin
                if (issued[k] && !returned[k] && done_cyc[k] == cyc) begin
                    due++;
                    returned[k] = 1'b1;
                end
            end
            assert (int'(credit_return) == due) else
                value_mismatch("credit_return", int'(credit_return), due);
            credits      = credits + int'(credit_return);
            credit_total = credit_total + int'(credit_return);
        end
    end

    // --------------------
    // Dispatcher
    // --------------------
    // Called at a falling edge, returns at the next one
    task automatic send(input int fu, input int p1, input int p2);
        int n;
        int t;
        int exp_entry;
        n = 0;
        while (credits == 0 && n < wait_limit) begin
            @(negedge clk);
            n++;
            stall_cycles++;
        end
        if (credits == 0) begin
            abort_run("no credit came back to the dispatcher");
        end else begin
            exp_entry = lowest_free_entry();
            assert (int'(alloc_index) == exp_entry) else
                value_mismatch("alloc_index", int'(alloc_index), exp_entry);
            t          = next_tag;
            next_tag   = next_tag + 1;
            prod[t][0] = (p1 >= 0 && !returned[p1]) ? p1 : -1;  // Done producer, no wait
            prod[t][1] = (p2 >= 0 && !returned[p2]) ? p2 : -1;
            dispatch       = '0;
            dispatch.valid = 1'b1;
            dispatch.fu    = fu_id_t'(fu);
            dispatch.tag   = tag_t'(t);
            if (prod[t][0] >= 0) begin
                dispatch.src1_en    = 1'b1;
                dispatch.src1_entry = entry_idx_t'(entry_of[p1]);
            end
            if (prod[t][1] >= 0) begin
                dispatch.src2_en    = 1'b1;
                dispatch.src2_entry = entry_idx_t'(entry_of[p2]);
            end
            entry_of[t] = int'(alloc_index);
            disp_cyc[t] = cyc + 1;
            fu_of[t]    = fu;
            sent[t]     = 1'b1;
            credits     = credits - 1;
            @(negedge clk);
            dispatch = '0;
        end
    endtask

    task automatic open_test();
        err_mark    = errors;
        tag_mark    = next_tag;
        credit_mark = credit_total;
    endtask

    // Drain, then the end-of-test checks and one report line
    task automatic close_test(input string name, input bit exact);
        int n;
        n = 0;
        while (credits != rs_entries && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (credits != rs_entries) begin
            abort_run($sformatf("credits not back during %s", name));
        end else begin
            for (int t = tag_mark; t < next_tag; t++) begin
                assert (issued[t] && returned[t]) else
                    protocol_fault($sformatf("tag %0d never completed", t));
                if (exact) begin
                    assert (issue_cyc[t] == disp_cyc[t] + 2) else
                        value_mismatch("issue cycle", issue_cyc[t], disp_cyc[t] + 2);
                end
            end
            assert (credit_total - credit_mark == next_tag - tag_mark) else
                value_mismatch("credit_return total", credit_total - credit_mark,
                               next_tag - tag_mark);
            tests_run++;
            if (errors == err_mark) begin
                tests_ok++;
            end
            $display("%s: %s", name, (errors == err_mark) ? "ok" : "FAILED");
        end
    endtask

    initial begin
        int p;
        int q;
        int stall_mark;
        int live [$];  // In-flight tags for random producers
        void'($urandom(32'h731e));
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst     = 1'b0;
        credits = rs_entries;

        open_test();
        repeat (10) @(negedge clk);
        close_test("idle after reset", 1'b0);

        for (int f = 0; f < num_fus; f++) begin
            open_test();
            send(f, -1, -1);
            close_test($sformatf("single on FU %0d", f), 1'b1);
        end

        open_test();
        p = next_tag;
        send(2, -1, -1);     // Multiply
        send(0, p, -1);      // ALU 0 on the product
        send(1, p + 1, -1);  // ALU 1 on the ALU 0 result
        send(2, p + 2, p);
        close_test("dependency chain", 1'b0);

        open_test();
        p = next_tag;
        send(2, -1, -1);     // Slow producer
        send(0, -1, -1);     // Fast producer
        send(1, p, p + 1);
        close_test("two sources", 1'b0);

        open_test();
        p          = next_tag;
        stall_mark = stall_cycles;
        send(2, -1, -1);
        send(2, p, -1);      // Second multiply holds the waiters back
        for (int i = 0; i < rs_entries; i++) begin
            send(i % 2, p + 1, -1);  // All wait on the second multiply
        end
        assert (stall_cycles > stall_mark) else
            protocol_fault("dispatcher never ran out of credits");
        close_test("credit exhaustion", 1'b0);

        open_test();
        for (int i = 0; i < 200; i++) begin
            live.delete();
            for (int t = tag_mark; t < next_tag; t++) begin
                if (sent[t] && !returned[t]) begin
                    live.push_back(t);
                end
            end
            p = -1;
            q = -1;
            if (live.size() > 0 && $urandom % 2 == 1) begin
                p = live[$urandom % live.size()];
            end
            if (live.size() > 0 && $urandom % 3 == 0) begin
                q = live[$urandom % live.size()];
            end
            send(int'($urandom % num_fus), p, q);
            if ($urandom % 4 == 0) begin
                @(negedge clk);  // Idle gap
            end
        end
        close_test("random stream", 1'b0);

        $display("Tests %0d, passed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_ok, errors, dut0.u_wakeup.u_props.fail_count);
        if (errors == 0 && dut0.u_wakeup.u_props.fail_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
